// ==== bench/partial_model.svh ====
// reference model for the sequencer testbench: greedy strobe split and seeded LCG
`ifndef PARTIAL_MODEL_SVH
`define PARTIAL_MODEL_SVH

// single random stream for the whole run
logic [31:0] lcg_state = 32'h40ec1705;

// numerical recipes constants, full 32-bit state
function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// largest size first, ascending offset within a size, tags from 0
function automatic void build_expected(input strb_t s, ref partial_cmd_t q[$]);
   strb_t        rem;
   partial_cmd_t c;
   int           size;
   int           tag;
   logic         full;
   rem = s;
   tag = 0;
   q.delete();
   for (int lv = 5; lv >= 0; lv--)
   begin
      size = 1 << lv;
      for (int base = 0; base < STRB_BYTES; base += size)
      begin
         full = 1'b1;
         for (int k = 0; k < size; k++)
         begin
            if (!rem[base + k])
            begin
               full = 1'b0;
            end
         end
         if (full)
         begin
            c.len = len_code_t'(lv);
            c.ea  = byte_ofs_t'(base);
            c.tag = tag_t'(tag);
            q.push_back(c);
            tag++;
            // issued bytes never show up again at a smaller size
            for (int k = 0; k < size; k++)
            begin
               rem[base + k] = 1'b0;
            end
         end
      end
   end
endfunction

`endif

// ==== bench/tb_partial_sequencer.sv ====
// testbench for the partial-access sequencer: directed and random strobe splits
`timescale 1ns/1ns

module tb_partial_sequencer;

   import partial_pkg::*;

   `include "partial_model.svh"

   localparam int RESET_CYCLES = 16;
   // whole beat, mixed, empty, alternating, 20 random
   localparam int NUM_STROBES  = 24;
   // 32 commands max per strobe with 8 cycles allowance each
   localparam int CYCLE_LIMIT  = NUM_STROBES * 32 * 8 + RESET_CYCLES;

   logic         clk;
   logic         rst_n;
   logic         strb_valid;
   logic         strb_ready;
   strb_t        strb;
   logic         cmd_valid;
   logic         cmd_ready;
   partial_cmd_t cmd;
   logic         seq_done;

   partial_cmd_t exp_q[$];
   partial_cmd_t rcv_q[$];
   int           mismatch_cnt = 0;
   int           other_cnt = 0;
   int           cycle_cnt = 0;
   // done pulses seen in the current strobe
   int           done_cnt = 0;
   // held command from the previous edge
   logic         hold_prev = 1'b0;
   partial_cmd_t cmd_prev;

   partial_sequencer uut
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .strb_valid (strb_valid),
      .strb_ready (strb_ready),
      .strb       (strb),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd        (cmd),
      .seq_done   (seq_done)
   );

   always #10 clk = ~clk;

   // ----------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------

   task automatic check_cmd(input string name, input partial_cmd_t got, input partial_cmd_t exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH t=%0t %s got len=%0d ea=%0d tag=%0d exp len=%0d ea=%0d tag=%0d",
                  $time, name, got.len, got.ea, got.tag, exp.len, exp.ea, exp.tag);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
      end
   endtask

   // ----------------------------------------------------------
   // monitor and cycle limit
   // ----------------------------------------------------------

   always @(posedge clk)
   begin
      if (rst_n)
      begin
         // stalled command must stay put
         if (hold_prev)
         begin
            check_bit("cmd_valid", cmd_valid, 1'b1);
            check_cmd("cmd held", cmd, cmd_prev);
         end
         if (cmd_valid && cmd_ready)
         begin
            rcv_q.push_back(cmd);
         end
         if (seq_done)
         begin
            done_cnt++;
         end
         hold_prev = cmd_valid && !cmd_ready;
         cmd_prev  = cmd;
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles, sequence never completed", cycle_cnt);
         $display("TEST FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------
   // stimulus helpers
   // ----------------------------------------------------------

   task automatic expect_cmd(input int len, input int ea, input int tag);
      partial_cmd_t c;
      c.len = len_code_t'(len);
      c.ea  = byte_ofs_t'(ea);
      c.tag = tag_t'(tag);
      exp_q.push_back(c);
   endtask

   // one strobe through the DUT, then compare against exp_q
   task automatic run_strobe(input strb_t s, input logic rand_ready);
      logic [31:0] r;
      rcv_q.delete();
      done_cnt = 0;
      @(posedge clk);
      strb_valid <= 1'b1;
      strb       <= s;
      @(posedge clk);
      while (!strb_ready)
      begin
         @(posedge clk);
      end
      strb_valid <= 1'b0;
      while (!seq_done)
      begin
         @(posedge clk);
         r = lcg_next();
         cmd_ready <= rand_ready ? r[16] : 1'b1;
      end
      cmd_ready <= 1'b1;
      @(posedge clk);
      check_bit("strb_ready", strb_ready, 1'b1);
      check_bit("seq_done", seq_done, 1'b0);
      @(posedge clk);
      check_bit("seq_done", seq_done, 1'b0);
      if (done_cnt != 1)
      begin
         other_cnt++;
         $display("wrong number of done pulses at %0t: got %0d, expected 1",
                  $time, done_cnt);
      end
      if (rcv_q.size() != exp_q.size())
      begin
         other_cnt++;
         $display("wrong command count at %0t: got %0d, expected %0d",
                  $time, rcv_q.size(), exp_q.size());
      end
      for (int i = 0; i < exp_q.size() && i < rcv_q.size(); i++)
      begin
         check_cmd($sformatf("cmd[%0d]", i), rcv_q[i], exp_q[i]);
      end
   endtask

   // ----------------------------------------------------------
   // directed tests
   // ----------------------------------------------------------

   task automatic test_reset();
      repeat (RESET_CYCLES / 2) @(posedge clk);
      check_bit("cmd_valid", cmd_valid, 1'b0);
      check_bit("seq_done", seq_done, 1'b0);
      check_bit("strb_ready", strb_ready, 1'b1);
      repeat (RESET_CYCLES / 2) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_bit("cmd_valid", cmd_valid, 1'b0);
      check_bit("seq_done", seq_done, 1'b0);
      check_bit("strb_ready", strb_ready, 1'b1);
   endtask

   // largest piece is 32B, so the beat splits into two halves
   task automatic test_whole_beat();
      exp_q.delete();
      expect_cmd(5, 0, 0);
      expect_cmd(5, 32, 1);
      run_strobe('1, 1'b0);
   endtask

   // 16B at 0, 4B at 24, then single odd bytes
   task automatic test_mixed();
      exp_q.delete();
      expect_cmd(4, 0, 0);
      expect_cmd(2, 24, 1);
      expect_cmd(0, 33, 2);
      expect_cmd(0, 35, 3);
      expect_cmd(0, 37, 4);
      run_strobe(64'h0000_002a_0f00_ffff, 1'b0);
   endtask

   task automatic test_empty();
      exp_q.delete();
      run_strobe('0, 1'b0);
   endtask

   // even bytes only give 32 single-byte commands
   task automatic test_backpressure();
      exp_q.delete();
      for (int i = 0; i < 32; i++)
      begin
         expect_cmd(0, 2 * i, i);
      end
      run_strobe({32{2'b01}}, 1'b1);
   endtask

   task automatic test_random();
      strb_t s;
      for (int n = 0; n < 20; n++)
      begin
         s = {lcg_next(), lcg_next()};
         // smear every other strobe into longer runs
         if (n % 2 == 1)
         begin
            s = s | (s >> 1) | (s >> 3);
         end
         build_expected(s, exp_q);
         run_strobe(s, 1'b1);
      end
   endtask

   initial
   begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      strb_valid = 1'b0;
      strb       = '0;
      cmd_ready  = 1'b1;
      test_reset();
      test_whole_beat();
      test_mixed();
      test_empty();
      test_backpressure();
      test_random();
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt + other_cnt == 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== logic/aligned_block_finder.sv ====
// aligned block finder: lowest fully enabled power-of-two block of one size in a strobe
`timescale 1ns/1ns

module aligned_block_finder
(
   input  partial_pkg::strb_t       rem_strb,
   input  partial_pkg::size_level_e level,
   output logic                     found,
   output partial_pkg::strb_t       blk_mask,
   output partial_pkg::byte_ofs_t   blk_ea
);

   import partial_pkg::*;

   // one row of block flags per size level
   // row lv has STRB_BYTES >> lv meaningful bits, upper bits zero
   strb_t [NUM_LEVELS-1:0] blk_flags;
   // flags of the currently addressed level
   strb_t                  sel_flags;
   // lowest set flag only
   strb_t                  pick;
   // block index of the picked flag
   byte_ofs_t              blk_idx;

   genvar lv;
   genvar b;

   // ----------------------------------------------------------
   // all-ones detection, every aligned block at every size
   // ----------------------------------------------------------

   generate
      for (lv = 0; lv < NUM_LEVELS; lv = lv + 1)
      begin : g_level
         // block b at this level covers bytes b*2^lv .. b*2^lv + 2^lv - 1
         for (b = 0; b < (STRB_BYTES >> lv); b = b + 1)
         begin : g_blk
            assign blk_flags[lv][b] = &rem_strb[b * (1 << lv) +: (1 << lv)];
         end

         // fewer blocks than bytes above 1B, pad the row
         if ((STRB_BYTES >> lv) < STRB_BYTES)
         begin : g_pad
            assign blk_flags[lv][STRB_BYTES-1:(STRB_BYTES >> lv)] = '0;
         end
      end
   endgenerate

   // ----------------------------------------------------------
   // level select and priority pick
   // ----------------------------------------------------------

   // one finder, addressed by the current size level
   assign sel_flags = blk_flags[level];

   // any complete block of this size left
   assign found = |sel_flags;

   // x & -x isolates the lowest set bit
   // lowest offset wins within one size
   assign pick = sel_flags & (~sel_flags + 1'b1);

   // ----------------------------------------------------------
   // offset encode and mask expand
   // ----------------------------------------------------------

   // pick is one-hot or zero, so or-ing indices is an encoder
   always_comb
   begin
      blk_idx = '0;
      for (int i = 0; i < STRB_BYTES; i++)
      begin
         if (pick[i])
         begin
            blk_idx = blk_idx | byte_ofs_t'(i);
         end
      end
   end

   // block index scaled by block size gives the start byte
   assign blk_ea = byte_ofs_t'(blk_idx << level);

   // byte j belongs to block j >> level
   always_comb
   begin
      for (int j = 0; j < STRB_BYTES; j++)
      begin
         blk_mask[j] = pick[j >> level];
      end
   end

endmodule

// ==== logic/partial_cmd_slot.sv ====
// output command slot: one-entry register with valid/ready and per-sequence tags
`timescale 1ns/1ns

module partial_cmd_slot
(
   input  logic                      clk,
   input  logic                      rst_n,
   // request from the controller
   input  logic                      issue,
   input  partial_pkg::partial_req_t req,
   output logic                      slot_free,
   // restarts tag numbering
   input  logic                      seq_done,
   // command output handshake
   output logic                      cmd_valid,
   input  logic                      cmd_ready,
   output partial_pkg::partial_cmd_t cmd
);

   import partial_pkg::*;

   // held command and its valid flag
   partial_cmd_t cmd_q;
   logic         valid_q;
   // completed commands in this sequence
   tag_t         tag_cnt;

   // request taken into the slot
   logic         accept;
   // held command leaves this cycle
   logic         done_beat;

   assign done_beat = valid_q && cmd_ready;

   // empty, or emptying now, allows back-to-back commands
   assign slot_free = !valid_q || cmd_ready;
   assign accept    = issue && slot_free;

   assign cmd_valid = valid_q;
   assign cmd       = cmd_q;

   // ----------------------------------------------------------
   // valid flag
   // ----------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= 1'b0;
      end
      else if (accept)
      begin
         valid_q <= 1'b1;
      end
      else if (done_beat)
      begin
         valid_q <= 1'b0;
      end
   end

   // ----------------------------------------------------------
   // command payload
   // ----------------------------------------------------------

   // held stable until the consumer takes it
   // tag counts the completion in this same cycle too
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         cmd_q.len <= req.len;
         cmd_q.ea  <= req.ea;
         cmd_q.tag <= tag_cnt + tag_t'(done_beat);
      end
   end

   // ----------------------------------------------------------
   // tag counter
   // ----------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tag_cnt <= '0;
      end
      else if (seq_done)
      begin
         // next sequence starts again at tag 0
         tag_cnt <= '0;
      end
      else if (done_beat)
      begin
         tag_cnt <= tag_cnt + 1'b1;
      end
   end

endmodule

// ==== logic/partial_pkg.sv ====
// partial sequencer package: beat widths, vector types, size levels and command structs
package partial_pkg;

   // ----------------------------------------------------------
   // widths
   // ----------------------------------------------------------

   // one data beat, one strobe bit per byte
   localparam int STRB_BYTES = 64;
   // byte offset within the beat
   localparam int OFS_W      = 6;
   // log2 of block size, 0..5
   localparam int LEN_W      = 3;
   // 32 commands max per beat (alternating bytes)
   localparam int TAG_W      = 5;
   // 32B, 16B, 8B, 4B, 2B, 1B
   localparam int NUM_LEVELS = 6;

   // ----------------------------------------------------------
   // vector types
   // ----------------------------------------------------------

   typedef logic [STRB_BYTES-1:0] strb_t;
   typedef logic [OFS_W-1:0]      byte_ofs_t;
   typedef logic [LEN_W-1:0]      len_code_t;
   typedef logic [TAG_W-1:0]      tag_t;

   // size level, value doubles as the length code
   typedef enum logic [LEN_W-1:0] {
      LVL_32B = 3'd5,
      LVL_16B = 3'd4,
      LVL_8B  = 3'd3,
      LVL_4B  = 3'd2,
      LVL_2B  = 3'd1,
      LVL_1B  = 3'd0
   } size_level_e;

   // ----------------------------------------------------------
   // command structs
   // ----------------------------------------------------------

   // controller to output slot, tag not yet known
   typedef struct packed {
      len_code_t len;
      byte_ofs_t ea;
   } partial_req_t;

   // command as seen on the output port
   typedef struct packed {
      len_code_t len;
      byte_ofs_t ea;
      tag_t      tag;
   } partial_cmd_t;

endpackage

// ==== logic/partial_seq_ctrl.sv ====
// partial sequence controller: takes a strobe, walks size levels, issues and clears blocks
`timescale 1ns/1ns

module partial_seq_ctrl
(
   input  logic                      clk,
   input  logic                      rst_n,
   // strobe input handshake
   input  logic                      strb_valid,
   output logic                      strb_ready,
   input  partial_pkg::strb_t        strb,
   // to and from the block finder
   output partial_pkg::strb_t        rem_strb,
   output partial_pkg::size_level_e  level,
   input  logic                      found,
   input  partial_pkg::strb_t        blk_mask,
   input  partial_pkg::byte_ofs_t    blk_ea,
   // to and from the output slot
   input  logic                      slot_free,
   output logic                      issue,
   output partial_pkg::partial_req_t req,
   // end of sequence
   output logic                      seq_done
);

   import partial_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      SCAN,
      FINISH
   } seq_state_e;

   seq_state_e state;
   seq_state_e state_nxt;

   // strobe handshake completes
   logic       take_strb;
   // slot takes the current block
   logic       accept;
   // nothing left to find at any smaller level
   logic       scan_end;

   // ----------------------------------------------------------
   // handshake and request
   // ----------------------------------------------------------

   // only idle may accept a new strobe
   assign strb_ready = (state == IDLE);
   assign take_strb  = strb_valid && strb_ready;

   // every finder hit during scan is a request
   assign issue   = (state == SCAN) && found;
   assign accept  = issue && slot_free;
   assign req.len = len_code_t'(level);
   assign req.ea  = blk_ea;

   // empty remainder, or smallest size exhausted
   assign scan_end = !found && ((rem_strb == '0) || (level == LVL_1B));

   // ----------------------------------------------------------
   // state machine
   // ----------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= IDLE;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:
         begin
            if (take_strb)
            begin
               state_nxt = SCAN;
            end
         end
         SCAN:
         begin
            // a hit stays here, also while the slot is busy
            if (scan_end)
            begin
               state_nxt = FINISH;
            end
         end
         FINISH:
         begin
            // leave together with the done pulse
            if (seq_done)
            begin
               state_nxt = IDLE;
            end
         end
         default:
         begin
            state_nxt = IDLE;
         end
      endcase
   end

   // ----------------------------------------------------------
   // remaining bytes and size level
   // ----------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rem_strb <= '0;
         level    <= LVL_32B;
      end
      else if (take_strb)
      begin
         // start from the largest size
         rem_strb <= strb;
         level    <= LVL_32B;
      end
      else if (state == SCAN)
      begin
         if (accept)
         begin
            // clear issued bytes, same level looks again
            rem_strb <= rem_strb & ~blk_mask;
         end
         else if (!found && !scan_end)
         begin
            // this size is exhausted
            level <= size_level_e'(level - 1'b1);
         end
      end
   end

   // ----------------------------------------------------------
   // completion pulse
   // ----------------------------------------------------------

   // slot free in finish means last command is done or finishing now
   // pulse one cycle later so it never overlaps a completion
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         seq_done <= 1'b0;
      end
      else
      begin
         seq_done <= (state == FINISH) && slot_free && !seq_done;
      end
   end

endmodule

// ==== logic/partial_sequencer.sv ====
// partial-access sequencer top: splits a 64-byte strobe into aligned power-of-two commands
`timescale 1ns/1ns

module partial_sequencer
(
   input  logic                      clk,
   input  logic                      rst_n,
   // strobe input
   input  logic                      strb_valid,
   output logic                      strb_ready,
   input  partial_pkg::strb_t        strb,
   // command output
   output logic                      cmd_valid,
   input  logic                      cmd_ready,
   output partial_pkg::partial_cmd_t cmd,
   // one pulse per strobe
   output logic                      seq_done
);

   import partial_pkg::*;

   // controller to finder
   strb_t        rem_strb;
   size_level_e  level;
   // finder to controller
   logic         found;
   strb_t        blk_mask;
   byte_ofs_t    blk_ea;
   // controller and slot
   logic         issue;
   partial_req_t req;
   logic         slot_free;

   // ----------------------------------------------------------
   // sequence control
   // ----------------------------------------------------------

   partial_seq_ctrl u_ctrl
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .strb_valid (strb_valid),
      .strb_ready (strb_ready),
      .strb       (strb),
      .rem_strb   (rem_strb),
      .level      (level),
      .found      (found),
      .blk_mask   (blk_mask),
      .blk_ea     (blk_ea),
      .slot_free  (slot_free),
      .issue      (issue),
      .req        (req),
      .seq_done   (seq_done)
   );

   // single finder, shared across all size levels
   aligned_block_finder u_finder
   (
      .rem_strb (rem_strb),
      .level    (level),
      .found    (found),
      .blk_mask (blk_mask),
      .blk_ea   (blk_ea)
   );

   // ----------------------------------------------------------
   // output register
   // ----------------------------------------------------------

   partial_cmd_slot u_slot
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .issue     (issue),
      .req       (req),
      .slot_free (slot_free),
      .seq_done  (seq_done),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd       (cmd)
   );

endmodule

// ==== sim.f ====
+incdir+bench
logic/partial_pkg.sv
logic/aligned_block_finder.sv
logic/partial_seq_ctrl.sv
logic/partial_cmd_slot.sv
logic/partial_sequencer.sv
bench/tb_partial_sequencer.sv
